//--- include/noc_macros.svh
// mesh size, buffer depth and data width shared by all NoC files
// NOC_COORD_W must be wide enough for both NOC_X_NUM-1 and NOC_Y_NUM-1
// NOC_FIFO_DEPTH must be 2 or more
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// mesh columns
`define NOC_X_NUM 2
// mesh rows
`define NOC_Y_NUM 2
// bits per coordinate
`define NOC_COORD_W 1

// flits per router input FIFO and per NI buffer
`define NOC_FIFO_DEPTH 4

// flit payload width
`define NOC_DATA_W 32

`endif

//--- source/noc_flit_pkg.sv
// flit types for the mesh links
// a flit word is read as a head only when its kind is head or head_tail
// head layout puts len in the low byte and the coordinates just above it
`include "noc_macros.svh"

package noc_flit_pkg;

	typedef enum logic [1:0] {
		head      = 2'd0,
		body      = 2'd1,
		tail      = 2'd2,
		head_tail = 2'd3  // packet without payload
	} flit_kind_t;

	typedef struct packed {
		logic [`NOC_DATA_W-4*`NOC_COORD_W-9:0] spare;
		logic [`NOC_COORD_W-1:0]               src_y;
		logic [`NOC_COORD_W-1:0]               src_x;
		logic [`NOC_COORD_W-1:0]               dst_y;
		logic [`NOC_COORD_W-1:0]               dst_x;
		logic [7:0]                            len;  // payload flits after head
	} flit_head_t;

	typedef union packed {
		flit_head_t              hdr;
		logic [`NOC_DATA_W-1:0]  data;
	} flit_word_u;

	typedef struct packed {
		flit_kind_t  kind;
		flit_word_u  word;
	} flit_t;

	typedef enum logic [2:0] {
		port_local = 3'd0,
		port_north = 3'd1,  // toward y-1
		port_east  = 3'd2,  // toward x+1
		port_south = 3'd3,  // toward y+1
		port_west  = 3'd4   // toward x-1
	} port_e;

endpackage

//--- source/noc_bus_pkg.sv
// NI bus request and NI register codes
// the master holds a request until ack and ack lasts a single cycle
// register codes are decoded from adr and unknown codes have no effect

package noc_bus_pkg;

	typedef struct packed {
		logic        stb;  // request strobe
		logic        wre;  // write enable
		logic [3:0]  adr;  // register code
		logic [31:0] dat;  // write data
	} ni_req_t;

	typedef enum logic [3:0] {
		// dst x, dst y and len in head layout, sends the head
		dest      = 4'h0,
		// one payload word of the open packet
		tx_data   = 4'h1,
		// count in [7:0], front kind in [9:8]
		rx_status = 4'h2,
		// pops one received flit word
		rx_data   = 4'h3
	} ni_addr_e;

endpackage

//--- source/flit_fifo.sv
// first-word fall-through flit FIFO of NOC_FIFO_DEPTH entries
// a push while full is dropped so writers must respect full_o
// flit_o is undefined while empty_o is high
`timescale 1ns/10ps
`include "noc_macros.svh"

module flit_fifo
	import noc_flit_pkg::*;
(
	input  logic  clk,
	input  logic  reset_i,
	input  logic  push_i,
	input  flit_t flit_i,
	input  logic  pop_i,
	output flit_t flit_o,
	output logic  full_o,
	output logic  empty_o
);

	localparam int DEPTH = `NOC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	flit_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign full_o  = (count == (PTR_W+1)'(DEPTH));
	assign empty_o = (count == '0);
	assign flit_o  = mem[rd_ptr];  // front entry

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or push with pop
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= flit_i;
		end
	end

endmodule

//--- source/port_arbiter.sv
// round-robin arbiter for one router output with five requesters
// a grant holds until advance_i moves a tail flit of the granted input
// grant_o is combinational while unlocked
`timescale 1ns/10ps

module port_arbiter (
	input  logic       clk,
	input  logic       reset_i,
	input  logic [4:0] req_i,
	input  logic [4:0] tail_i,
	input  logic       advance_i,
	output logic [4:0] grant_o
);

	logic       locked;
	logic [4:0] lock_grant;
	logic [2:0] last;      // previous winner
	logic [4:0] pick;
	logic [2:0] pick_idx;

	// search starts just after the previous winner
	always_comb begin
		int idx;
		pick     = '0;
		pick_idx = last;
		for (int k = 5; k >= 1; k--) begin  // nearest one written last
			idx = (int'(last) + k) % 5;
			if (req_i[idx]) begin
				pick     = 5'b00001 << idx;
				pick_idx = 3'(idx);
			end
		end
	end

	assign grant_o = locked ? lock_grant : pick;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			locked     <= 1'b0;
			lock_grant <= '0;
			last       <= '0;
		end else begin
			if (advance_i && |(grant_o & tail_i)) begin
				locked <= 1'b0;  // packet done
			end else if (|grant_o) begin
				locked     <= 1'b1;
				lock_grant <= grant_o;
			end
			if (!locked && |pick) begin
				last <= pick_idx;
			end
		end
	end

endmodule

//--- source/mesh_router.sv
// five-port wormhole router with XY routing and one FIFO per input
// ports are indexed by port_e and north points to y-1
// a flit pushed into an input FIFO can leave on the next edge
// ports on the mesh edge must see out_full_i held high
`timescale 1ns/10ps
`include "noc_macros.svh"

module mesh_router
	import noc_flit_pkg::*;
#(
	parameter int ROUTER_X = 0,
	parameter int ROUTER_Y = 0
) (
	input  logic        clk,
	input  logic        reset_i,
	input  flit_t [4:0] in_flit_i,
	input  logic  [4:0] in_valid_i,
	output logic  [4:0] in_full_o,
	output flit_t [4:0] out_flit_o,
	output logic  [4:0] out_valid_o,
	input  logic  [4:0] out_full_i
);

	localparam logic [`NOC_COORD_W-1:0] SELF_X = ROUTER_X[`NOC_COORD_W-1:0];
	localparam logic [`NOC_COORD_W-1:0] SELF_Y = ROUTER_Y[`NOC_COORD_W-1:0];

	flit_t [4:0]      fifo_flit;
	logic  [4:0]      fifo_empty;
	logic  [4:0]      fifo_pop;
	logic  [4:0]      is_last;   // front flit closes its packet
	port_e            xy_port [5];
	port_e            route_q [5];  // held for body flits
	port_e            route   [5];
	logic  [4:0][4:0] req_m;     // [output][input]
	logic  [4:0][4:0] grant_m;   // [output][input]

	// x first, then y, then local
	function automatic port_e xy_route(flit_head_t hdr);
		if (hdr.dst_x > SELF_X) begin
			return port_east;
		end else if (hdr.dst_x < SELF_X) begin
			return port_west;
		end else if (hdr.dst_y > SELF_Y) begin
			return port_south;
		end else if (hdr.dst_y < SELF_Y) begin
			return port_north;
		end
		return port_local;
	endfunction

	for (genvar i = 0; i < 5; i++) begin : g_in
		flit_fifo u_fifo (
			.clk     (clk),
			.reset_i (reset_i),
			.push_i  (in_valid_i[i]),
			.flit_i  (in_flit_i[i]),
			.pop_i   (fifo_pop[i]),
			.flit_o  (fifo_flit[i]),
			.full_o  (in_full_o[i]),
			.empty_o (fifo_empty[i])
		);
	end

	for (genvar o = 0; o < 5; o++) begin : g_out
		port_arbiter u_arb (
			.clk       (clk),
			.reset_i   (reset_i),
			.req_i     (req_m[o]),
			.tail_i    (is_last),
			.advance_i (out_valid_o[o]),
			.grant_o   (grant_m[o])
		);
	end

	always_comb begin
		for (int i = 0; i < 5; i++) begin
			xy_port[i] = xy_route(fifo_flit[i].word.hdr);
			is_last[i] = (fifo_flit[i].kind == tail) || (fifo_flit[i].kind == head_tail);
			if (fifo_flit[i].kind == head || fifo_flit[i].kind == head_tail) begin
				route[i] = xy_port[i];
			end else begin
				route[i] = route_q[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 5; i++) begin
				route_q[i] <= port_local;
			end
		end else begin
			for (int i = 0; i < 5; i++) begin
				if (fifo_pop[i] && fifo_flit[i].kind == head) begin
					route_q[i] <= xy_port[i];  // rest of packet follows
				end
			end
		end
	end

	always_comb begin
		for (int o = 0; o < 5; o++) begin
			for (int i = 0; i < 5; i++) begin
				req_m[o][i] = !fifo_empty[i] && (route[i] == port_e'(o));
			end
		end
	end

	// crossbar
	always_comb begin
		for (int o = 0; o < 5; o++) begin
			out_flit_o[o] = '0;
			for (int i = 0; i < 5; i++) begin
				if (grant_m[o][i]) begin
					out_flit_o[o] = fifo_flit[i];
				end
			end
			out_valid_o[o] = |(grant_m[o] & req_m[o]) && !out_full_i[o];
		end
	end

	always_comb begin
		for (int i = 0; i < 5; i++) begin
			fifo_pop[i] = 1'b0;
			for (int o = 0; o < 5; o++) begin
				if (grant_m[o][i] && out_valid_o[o]) begin
					fifo_pop[i] = 1'b1;
				end
			end
		end
	end

endmodule

//--- source/noc_ni.sv
// network interface on the router local port
// dest write data uses the flit_head_t layout and only dst_x, dst_y and len matter
// a new dest write must wait until the previous packet is complete
// a tx_data write outside a packet is acknowledged and dropped
// reads of other registers return zero
`timescale 1ns/10ps
`include "noc_macros.svh"

module noc_ni
	import noc_flit_pkg::*, noc_bus_pkg::*;
#(
	parameter int NODE_X = 0,
	parameter int NODE_Y = 0
) (
	input  logic        clk,
	input  logic        reset_i,
	input  ni_req_t     bus_req_i,
	output logic        bus_ack_o,
	output logic [31:0] bus_dat_o,
	output flit_t       tx_flit_o,
	output logic        tx_valid_o,
	input  logic        tx_full_i,
	input  flit_t       rx_flit_i,
	input  logic        rx_valid_i,
	output logic        rx_full_o
);

	flit_t      tx_in;
	logic       tx_push;
	logic       tx_full;
	logic       tx_empty;
	flit_t      rx_front;
	logic       rx_push;
	logic       rx_pop;
	logic       rx_empty;
	logic [7:0] rx_cnt;
	logic [7:0] remain;      // payload flits still expected
	logic       ack_q;
	logic       accept;
	logic       tx_wr;       // write into the transmit path
	ni_addr_e   adr;
	flit_head_t wr_hdr;
	logic [1:0] front_kind;

	flit_fifo u_tx_fifo (
		.clk     (clk),
		.reset_i (reset_i),
		.push_i  (tx_push),
		.flit_i  (tx_in),
		.pop_i   (tx_valid_o),
		.flit_o  (tx_flit_o),
		.full_o  (tx_full),
		.empty_o (tx_empty)
	);

	flit_fifo u_rx_fifo (
		.clk     (clk),
		.reset_i (reset_i),
		.push_i  (rx_push),
		.flit_i  (rx_flit_i),
		.pop_i   (rx_pop),
		.flit_o  (rx_front),
		.full_o  (rx_full_o),
		.empty_o (rx_empty)
	);

	assign adr        = ni_addr_e'(bus_req_i.adr);
	assign wr_hdr     = bus_req_i.dat;
	assign tx_wr      = bus_req_i.wre && (adr == dest || adr == tx_data);
	assign accept     = bus_req_i.stb && !ack_q && !(tx_wr && tx_full);  // held while full
	assign bus_ack_o  = ack_q;
	assign tx_valid_o = !tx_empty && !tx_full_i;
	assign rx_push    = rx_valid_i && !rx_full_o;
	assign rx_pop     = accept && !bus_req_i.wre && adr == rx_data && !rx_empty;
	assign front_kind = rx_empty ? 2'b00 : rx_front.kind;

	always_comb begin
		tx_in   = '0;
		tx_push = 1'b0;
		if (accept && tx_wr) begin
			if (adr == dest) begin
				tx_push              = 1'b1;
				tx_in.kind           = (wr_hdr.len == '0) ? head_tail : head;
				tx_in.word.hdr.dst_x = wr_hdr.dst_x;
				tx_in.word.hdr.dst_y = wr_hdr.dst_y;
				tx_in.word.hdr.src_x = NODE_X[`NOC_COORD_W-1:0];  // own position
				tx_in.word.hdr.src_y = NODE_Y[`NOC_COORD_W-1:0];
				tx_in.word.hdr.len   = wr_hdr.len;
			end else if (remain != '0) begin
				tx_push         = 1'b1;
				tx_in.kind      = (remain == 8'd1) ? tail : body;
				tx_in.word.data = bus_req_i.dat;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q  <= 1'b0;
			remain <= '0;
			rx_cnt <= '0;
		end else begin
			ack_q <= accept;
			if (accept && tx_wr && adr == dest) begin
				remain <= wr_hdr.len;
			end else if (tx_push) begin
				remain <= remain - 1'b1;
			end
			case ({rx_push, rx_pop})
				2'b10:   rx_cnt <= rx_cnt + 1'b1;
				2'b01:   rx_cnt <= rx_cnt - 1'b1;
				default: rx_cnt <= rx_cnt;
			endcase
		end
	end

	// read data lands with the ack
	always_ff @(posedge clk) begin
		if (accept && !bus_req_i.wre) begin
			case (adr)
				rx_status: bus_dat_o <= {22'd0, front_kind, rx_cnt};
				rx_data:   bus_dat_o <= rx_empty ? '0 : rx_front.word.data;
				default:   bus_dat_o <= '0;
			endcase
		end
	end

endmodule

//--- source/mesh_noc.sv
// mesh of routers with one NI per node, sized by the macros header
// node index is x + NOC_X_NUM * y and the NI bus arrays follow it
// ports on the mesh edge see no valid flits and a full level held high
`timescale 1ns/10ps
`include "noc_macros.svh"

module mesh_noc
	import noc_flit_pkg::*, noc_bus_pkg::*;
(
	input  logic                                              clk,
	input  logic                                              reset_i,
	input  ni_req_t [`NOC_X_NUM*`NOC_Y_NUM-1:0]               ni_req_i,
	output logic    [`NOC_X_NUM*`NOC_Y_NUM-1:0]               ni_ack_o,
	output logic    [`NOC_X_NUM*`NOC_Y_NUM-1:0][31:0]         ni_dat_o
);

	localparam int X_NUM = `NOC_X_NUM;
	localparam int Y_NUM = `NOC_Y_NUM;
	localparam int NODES = X_NUM * Y_NUM;

	flit_t [4:0] in_flit   [NODES];
	logic  [4:0] in_valid  [NODES];
	logic  [4:0] in_full   [NODES];
	flit_t [4:0] out_flit  [NODES];
	logic  [4:0] out_valid [NODES];
	logic  [4:0] out_full  [NODES];

	for (genvar y = 0; y < Y_NUM; y++) begin : g_row
		for (genvar x = 0; x < X_NUM; x++) begin : g_col
			localparam int N = x + X_NUM * y;

			mesh_router #(
				.ROUTER_X (x),
				.ROUTER_Y (y)
			) u_router (
				.clk         (clk),
				.reset_i     (reset_i),
				.in_flit_i   (in_flit[N]),
				.in_valid_i  (in_valid[N]),
				.in_full_o   (in_full[N]),
				.out_flit_o  (out_flit[N]),
				.out_valid_o (out_valid[N]),
				.out_full_i  (out_full[N])
			);

			noc_ni #(
				.NODE_X (x),
				.NODE_Y (y)
			) u_ni (
				.clk        (clk),
				.reset_i    (reset_i),
				.bus_req_i  (ni_req_i[N]),
				.bus_ack_o  (ni_ack_o[N]),
				.bus_dat_o  (ni_dat_o[N]),
				.tx_flit_o  (in_flit[N][port_local]),
				.tx_valid_o (in_valid[N][port_local]),
				.tx_full_i  (in_full[N][port_local]),
				.rx_flit_i  (out_flit[N][port_local]),
				.rx_valid_i (out_valid[N][port_local]),
				.rx_full_o  (out_full[N][port_local])
			);

			for (genvar d = 1; d < 5; d++) begin : g_dir
				localparam int NX  = (d == int'(port_east)) ? x + 1 :
				                     (d == int'(port_west)) ? x - 1 : x;
				localparam int NY  = (d == int'(port_south)) ? y + 1 :
				                     (d == int'(port_north)) ? y - 1 : y;
				localparam int OPP = (d + 1) % 4 + 1;  // facing port on the neighbor
				localparam int NB  = NX + X_NUM * NY;

				if (NX >= 0 && NX < X_NUM && NY >= 0 && NY < Y_NUM) begin : g_link
					assign in_flit[N][d]  = out_flit[NB][OPP];
					assign in_valid[N][d] = out_valid[NB][OPP];
					assign out_full[N][d] = in_full[NB][OPP];
				end else begin : g_edge
					assign in_flit[N][d]  = '0;
					assign in_valid[N][d] = 1'b0;
					assign out_full[N][d] = 1'b1;  // nothing may leave here
				end
			end
		end
	end

endmodule

//--- bench/mesh_noc_tb.sv
// directed testbench for the mesh NoC, bus inputs change 1 ns after the rising edge
// node n sits at x = n % NOC_X_NUM and y = n / NOC_X_NUM
// the run stops with $fatal at the first error or bus timeout
`timescale 1ns/10ps
`include "noc_macros.svh"

module mesh_noc_tb
	import noc_flit_pkg::*, noc_bus_pkg::*;
();

	localparam int NODES       = `NOC_X_NUM * `NOC_Y_NUM;
	localparam int BUS_TIMEOUT = 2000;  // cycles per bus transfer
	localparam int RX_POLLS    = 400;   // status reads per flit

	logic                      clk;
	logic                      reset_i;
	ni_req_t [NODES-1:0]       ni_req;
	logic    [NODES-1:0]       ni_ack;
	logic    [NODES-1:0][31:0] ni_dat;
	logic [31:0]               lfsr_state;
	logic [31:0]               sb_q [NODES*NODES][$];  // [dst*NODES+src], len then words
	logic [31:0]               words_q [NODES][$];     // next payload per source
	int                        dst_sel [NODES];
	int                        rx_need [NODES];

	mesh_noc u_mesh_noc (
		.clk      (clk),
		.reset_i  (reset_i),
		.ni_req_i (ni_req),
		.ni_ack_o (ni_ack),
		.ni_dat_o (ni_dat)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
	                           input logic [31:0] act);
		if (exp !== act) begin
			abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] head_word(input int dst, input int src, input int len);
		flit_head_t h;
		h       = '0;
		h.dst_x = `NOC_COORD_W'(dst % `NOC_X_NUM);
		h.dst_y = `NOC_COORD_W'(dst / `NOC_X_NUM);
		h.src_x = `NOC_COORD_W'(src % `NOC_X_NUM);
		h.src_y = `NOC_COORD_W'(src / `NOC_X_NUM);
		h.len   = 8'(len);
		return h;
	endfunction

	task automatic bus_transfer(input int node, input logic wre, input ni_addr_e adr,
	                            input logic [31:0] wdat, output logic [31:0] rdat);
		int cycles;
		cycles             = 0;
		ni_req[node].stb   = 1'b1;
		ni_req[node].wre   = wre;
		ni_req[node].adr   = adr;
		ni_req[node].dat   = wdat;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > BUS_TIMEOUT) begin
				abort_run($sformatf("Timeout: node %0d never acknowledged a bus request", node));
			end
		end while (ni_ack[node] !== 1'b1);
		rdat         = ni_dat[node];
		ni_req[node] = '0;
		@(posedge clk);  // idle cycle between transfers
		#1;
	endtask

	task automatic bus_write(input int node, input ni_addr_e adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_transfer(node, 1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input int node, input ni_addr_e adr, output logic [31:0] rdat);
		bus_transfer(node, 1'b0, adr, '0, rdat);
	endtask

	task automatic rx_wait(input int node, output logic [31:0] status);
		int polls;
		polls = 0;
		bus_read(node, rx_status, status);
		while (status[7:0] == 8'd0) begin
			polls++;
			if (polls > RX_POLLS) begin
				abort_run($sformatf("Timeout: no flit arrived at node %0d", node));
			end
			bus_read(node, rx_status, status);
		end
	endtask

	task automatic read_flit(input int node, output logic [1:0] kind, output logic [31:0] word);
		logic [31:0] status;
		rx_wait(node, status);
		kind = status[9:8];  // kind of the front flit
		bus_read(node, rx_data, word);
	endtask

	// scoreboard entry first, the head can only arrive after the dest write
	task automatic send_packet(input int src, input int dst);
		int key;
		int len;
		key = dst * NODES + src;
		len = words_q[src].size();
		sb_q[key].push_back(32'(len));
		for (int i = 0; i < len; i++) begin
			sb_q[key].push_back(words_q[src][i]);
		end
		bus_write(src, dest, head_word(dst, 0, len));
		for (int i = 0; i < len; i++) begin
			bus_write(src, tx_data, words_q[src][i]);
		end
	endtask

	task automatic receive_packet(input int node, input string name);
		logic [1:0]  kind;
		logic [31:0] word;
		flit_head_t  hdr;
		int          src;
		int          key;
		int          len;
		read_flit(node, kind, word);
		hdr = word;
		src = int'(hdr.src_x) + `NOC_X_NUM * int'(hdr.src_y);
		key = node * NODES + src;
		if (sb_q[key].size() == 0) begin
			abort_run($sformatf("%s: unexpected packet from node %0d at node %0d",
			                    name, src, node));
		end
		len = int'(sb_q[key].pop_front());
		check_value(name, (len == 0) ? head_tail : head, kind);
		check_value(name, head_word(node, src, len), word);
		for (int i = 0; i < len; i++) begin
			read_flit(node, kind, word);  // must follow the head directly
			check_value(name, (i == len - 1) ? tail : body, kind);
			check_value(name, sb_q[key].pop_front(), word);
		end
	endtask

	task automatic fill_pattern(input int src, input int pkt, input int len);
		words_q[src].delete();
		for (int i = 0; i < len; i++) begin
			words_q[src].push_back({8'(8'hA0 + src), 8'(pkt), 16'(i)});
		end
	endtask

	task automatic send_series(input int src, input int dst, input int count, input int len0);
		for (int p = 0; p < count; p++) begin
			fill_pattern(src, p, len0 + p);
			send_packet(src, dst);
		end
	endtask

	task automatic expect_stall(input string name, input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			#1;
			for (int n = 0; n < 2; n++) begin  // nodes 0 and 1 are sending
				check_value(name, 1, ni_req[n].stb);
				check_value(name, 0, ni_ack[n]);
			end
		end
	endtask

	task automatic test_reset();
		logic [31:0] d;
		for (int n = 0; n < NODES; n++) begin
			bus_read(n, rx_status, d);
			check_value("reset rx_status", 0, d);
			bus_read(n, rx_data, d);  // empty buffer still acks
			check_value("reset rx_data", 0, d);
		end
	endtask

	task automatic test_single();
		fill_pattern(0, 0, 3);
		send_packet(0, 3);
		receive_packet(3, "single three words");
		fill_pattern(0, 1, 0);
		send_packet(0, 3);
		receive_packet(3, "single empty packet");
	endtask

	task automatic test_many_to_one();
		fork
			send_series(0, 3, 3, 2);
			send_series(1, 3, 3, 2);
			send_series(2, 3, 3, 2);
			repeat (9) receive_packet(3, "many to one");
		join
	endtask

	task automatic test_backpressure();
		logic [31:0] d;
		fork
			send_series(0, 3, 2, 12);  // far more flits than the path holds
			send_series(1, 3, 2, 12);
			begin
				repeat (150) @(posedge clk);
				#1;
				expect_stall("backpressure stall", 20);
				bus_read(3, rx_status, d);
				check_value("backpressure rx_status", `NOC_FIFO_DEPTH, d);
				repeat (4) receive_packet(3, "backpressure drain");
			end
		join
	endtask

	// each round sends one packet per node, then all nodes drain
	task automatic test_random();
		int len;
		for (int r = 0; r < 6; r++) begin
			for (int n = 0; n < NODES; n++) begin
				rx_need[n] = 0;
			end
			for (int n = 0; n < NODES; n++) begin
				dst_sel[n] = int'(lfsr_bits(2));
				if (r == 0) begin
					dst_sel[n] = n;  // self traffic
				end
				len = int'(lfsr_bits(3)) % 6;
				words_q[n].delete();
				for (int i = 0; i < len; i++) begin
					words_q[n].push_back(lfsr_bits(32));
				end
				rx_need[dst_sel[n]]++;
			end
			fork
				send_packet(0, dst_sel[0]);
				send_packet(1, dst_sel[1]);
				send_packet(2, dst_sel[2]);
				send_packet(3, dst_sel[3]);
			join
			fork
				repeat (rx_need[0]) receive_packet(0, "random");
				repeat (rx_need[1]) receive_packet(1, "random");
				repeat (rx_need[2]) receive_packet(2, "random");
				repeat (rx_need[3]) receive_packet(3, "random");
			join
		end
	endtask

	initial begin
		clk        = 1'b0;
		reset_i    = 1'b1;
		ni_req     = '0;
		lfsr_state = 32'had58;
		repeat (2) @(posedge clk);
		#1;
		reset_i = 1'b0;
		test_reset();
		test_single();
		test_many_to_one();
		test_backpressure();
		test_random();
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- mesh_noc.f
+incdir+include
source/noc_flit_pkg.sv
source/noc_bus_pkg.sv
source/flit_fifo.sv
source/port_arbiter.sv
source/mesh_router.sv
source/noc_ni.sv
source/mesh_noc.sv
bench/mesh_noc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the mesh NoC testbench with Verilator and run it
# exit status is nonzero when the simulation stops on $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
	-f mesh_noc.f \
	--top-module mesh_noc_tb \
	-o mesh_noc_sim
./obj_dir/mesh_noc_sim
